// ==== logic/noc_defs.svh ====
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Router geometry
//////////////////////////////////////////////////////////////////////

// Local, north, east, south, west
`define NOC_PORTS      5

// One mesh coordinate
`define NOC_COORD_W    3

//////////////////////////////////////////////////////////////////////
// Flit and queue sizing
//////////////////////////////////////////////////////////////////////

`define NOC_PAYLOAD_W  16

// Entries per input queue
`define NOC_FIFO_DEPTH 4

// x, then y, then one enable bit per output
`define NOC_CFG_W      11

`endif

// ==== logic/noc_pkg.sv ====
`include "noc_defs.svh"

package noc_pkg;

   // Mesh coordinate
   typedef logic [`NOC_COORD_W-1:0] coord_t;

   // One bit per router port
   typedef logic [`NOC_PORTS-1:0] port_vec_t;

   // Configuration register contents
   typedef logic [`NOC_CFG_W-1:0] cfg_word_t;

   //////////////////////////////////////////////////////////////////////
   // Flit format
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                      last;
      coord_t                    dest_x;
      coord_t                    dest_y;
      logic [`NOC_PAYLOAD_W-1:0] payload;
   } flit_t;

   //////////////////////////////////////////////////////////////////////
   // Output arbiter states
   //////////////////////////////////////////////////////////////////////

   // One-hot grant states, idle is all zero
   typedef enum logic [`NOC_PORTS-1:0] {
      arb_idle = 5'b00000,
      arb_gnt0 = 5'b00001,
      arb_gnt1 = 5'b00010,
      arb_gnt2 = 5'b00100,
      arb_gnt3 = 5'b01000,
      arb_gnt4 = 5'b10000
   } arb_state_e;

endpackage

// ==== logic/router_cfg.sv ====
`timescale 1ns/10ps
`include "noc_defs.svh"

module router_cfg
(
   input  logic               clk,
   input  logic               rst,
   input  logic               cfg_we,
   input  noc_pkg::cfg_word_t cfg_wdata,
   output noc_pkg::cfg_word_t cfg_rdata,
   output noc_pkg::coord_t    my_x,
   output noc_pkg::coord_t    my_y,
   output noc_pkg::port_vec_t out_en
);

   // Field positions in the configuration word
   localparam int en_lsb = 0;
   localparam int y_lsb  = `NOC_PORTS;
   localparam int x_lsb  = `NOC_PORTS + `NOC_COORD_W;

   // Coordinates (0,0) with every output enabled
   localparam noc_pkg::cfg_word_t cfg_default =
      {{(2 * `NOC_COORD_W){1'b0}}, {`NOC_PORTS{1'b1}}};

   noc_pkg::cfg_word_t cfg_q;

   //////////////////////////////////////////////////////////////////////
   // Configuration register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         cfg_q <= cfg_default;
      else if (cfg_we)
         cfg_q <= cfg_wdata;
   end

   // Field split toward routing and arbitration
   assign my_x   = cfg_q[x_lsb +: `NOC_COORD_W];
   assign my_y   = cfg_q[y_lsb +: `NOC_COORD_W];
   assign out_en = cfg_q[en_lsb +: `NOC_PORTS];

   // Whole word for readback
   assign cfg_rdata = cfg_q;

endmodule

// ==== logic/input_unit.sv ====
`timescale 1ns/10ps
`include "noc_defs.svh"

module input_unit
(
   input  logic               clk,
   input  logic               rst,
   input  logic               in_valid,
   input  noc_pkg::flit_t     in_flit,
   output logic               in_full,
   input  noc_pkg::coord_t    my_x,
   input  noc_pkg::coord_t    my_y,
   input  noc_pkg::port_vec_t gnt,
   output noc_pkg::port_vec_t req,
   output noc_pkg::port_vec_t pop_req,
   output noc_pkg::flit_t     head_flit
);

   localparam int ptr_w = $clog2(`NOC_FIFO_DEPTH);
   localparam int cnt_w = $clog2(`NOC_FIFO_DEPTH + 1);

   // Port numbering of the router
   localparam int port_local = 0;
   localparam int port_north = 1;
   localparam int port_east  = 2;
   localparam int port_south = 3;
   localparam int port_west  = 4;

   noc_pkg::flit_t     fifo_mem [0:`NOC_FIFO_DEPTH-1];
   logic [ptr_w-1:0]   wr_ptr;
   logic [ptr_w-1:0]   rd_ptr;
   logic [cnt_w-1:0]   count;
   logic               empty;
   logic               push;
   logic               pop;
   logic               pkt_active;
   noc_pkg::port_vec_t route_q;
   noc_pkg::port_vec_t route_head;

   assign empty     = (count == '0);
   assign in_full   = (count == cnt_w'(`NOC_FIFO_DEPTH));
   assign push      = in_valid && !in_full;
   assign head_flit = fifo_mem[rd_ptr];

   //////////////////////////////////////////////////////////////////////
   // XY route of the flit at the queue head
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      route_head = '0;
      if (head_flit.dest_x > my_x)
         route_head[port_east] = 1'b1;
      else if (head_flit.dest_x < my_x)
         route_head[port_west] = 1'b1;
      else if (head_flit.dest_y > my_y)
         route_head[port_north] = 1'b1;
      else if (head_flit.dest_y < my_y)
         route_head[port_south] = 1'b1;
      else
         route_head[port_local] = 1'b1;
   end

   // Mid-packet the latched route holds the request, even when drained
   assign req     = pkt_active ? route_q : (empty ? '0 : route_head);
   assign pop_req = empty ? '0 : req;
   assign pop     = |(pop_req & gnt);

   //////////////////////////////////////////////////////////////////////
   // Circular flit queue
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (push)
         fifo_mem[wr_ptr] <= in_flit;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == ptr_w'(`NOC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == ptr_w'(`NOC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Packet lock, set by a popped head and cleared by the popped tail
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pkt_active <= 1'b0;
         route_q    <= '0;
      end
      else if (pop)
      begin
         pkt_active <= !head_flit.last;
         if (!pkt_active)
            route_q <= route_head;
      end
   end

endmodule

// ==== logic/port_arbiter.sv ====
`timescale 1ns/10ps

module port_arbiter
(
   input  logic               clk,
   input  logic               rst,
   input  noc_pkg::port_vec_t req,
   input  logic               en,
   output noc_pkg::port_vec_t gnt
);

   noc_pkg::arb_state_e state;
   noc_pkg::arb_state_e next_state;

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= noc_pkg::arb_idle;
      else
         state <= next_state;
   end

   //////////////////////////////////////////////////////////////////////
   // Next state
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      next_state = state;
      case (state)
         noc_pkg::arb_idle:
         begin
            // Lowest-numbered requester wins, only while enabled
            if (!en)
               next_state = noc_pkg::arb_idle;
            else if (req[0])
               next_state = noc_pkg::arb_gnt0;
            else if (req[1])
               next_state = noc_pkg::arb_gnt1;
            else if (req[2])
               next_state = noc_pkg::arb_gnt2;
            else if (req[3])
               next_state = noc_pkg::arb_gnt3;
            else if (req[4])
               next_state = noc_pkg::arb_gnt4;
         end
         // Grant held as long as its owner asks
         noc_pkg::arb_gnt0:
            if (!req[0])
               next_state = noc_pkg::arb_idle;
         noc_pkg::arb_gnt1:
            if (!req[1])
               next_state = noc_pkg::arb_idle;
         noc_pkg::arb_gnt2:
            if (!req[2])
               next_state = noc_pkg::arb_idle;
         noc_pkg::arb_gnt3:
            if (!req[3])
               next_state = noc_pkg::arb_idle;
         noc_pkg::arb_gnt4:
            if (!req[4])
               next_state = noc_pkg::arb_idle;
         default:
            next_state = noc_pkg::arb_idle;
      endcase
   end

   // Grant decode
   always_comb
   begin
      case (state)
         noc_pkg::arb_gnt0: gnt = 5'b00001;
         noc_pkg::arb_gnt1: gnt = 5'b00010;
         noc_pkg::arb_gnt2: gnt = 5'b00100;
         noc_pkg::arb_gnt3: gnt = 5'b01000;
         noc_pkg::arb_gnt4: gnt = 5'b10000;
         default:           gnt = 5'b00000;
      endcase
   end

endmodule

// ==== logic/crossbar.sv ====
`timescale 1ns/10ps
`include "noc_defs.svh"

module crossbar
(
   input  logic               clk,
   input  logic               rst,
   input  noc_pkg::port_vec_t gnt_by_out [0:`NOC_PORTS-1],
   input  noc_pkg::flit_t     head_flit  [0:`NOC_PORTS-1],
   input  noc_pkg::port_vec_t req_by_out [0:`NOC_PORTS-1],
   output noc_pkg::port_vec_t out_valid,
   output noc_pkg::flit_t     out_flit   [0:`NOC_PORTS-1]
);

   noc_pkg::flit_t     sel_flit [0:`NOC_PORTS-1];
   noc_pkg::port_vec_t sel_valid;

   //////////////////////////////////////////////////////////////////////
   // Per-output select of the granted input
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int j = 0; j < `NOC_PORTS; j++)
      begin
         sel_flit[j] = '0;
         // Same condition the input unit pops on
         sel_valid[j] = |(gnt_by_out[j] & req_by_out[j]);
         for (int i = 0; i < `NOC_PORTS; i++)
         begin
            if (gnt_by_out[j][i])
               sel_flit[j] = head_flit[i];
         end
      end
   end

   // Output registers
   always_ff @(posedge clk)
   begin
      if (rst)
         out_valid <= '0;
      else
         out_valid <= sel_valid;
   end

   always_ff @(posedge clk)
   begin
      for (int j = 0; j < `NOC_PORTS; j++)
      begin
         if (sel_valid[j])
            out_flit[j] <= sel_flit[j];
      end
   end

endmodule

// ==== logic/mesh_router.sv ====
`timescale 1ns/10ps
`include "noc_defs.svh"

module mesh_router
(
   input  logic               clk,
   input  logic               rst,
   input  noc_pkg::port_vec_t in_valid,
   input  noc_pkg::flit_t     in_flit   [0:`NOC_PORTS-1],
   output noc_pkg::port_vec_t in_full,
   output noc_pkg::port_vec_t out_valid,
   output noc_pkg::flit_t     out_flit  [0:`NOC_PORTS-1],
   input  logic               cfg_we,
   input  noc_pkg::cfg_word_t cfg_wdata,
   output noc_pkg::cfg_word_t cfg_rdata
);

   noc_pkg::coord_t    my_x;
   noc_pkg::coord_t    my_y;
   noc_pkg::port_vec_t out_en;

   // Indexed by input port
   noc_pkg::port_vec_t req_by_in  [0:`NOC_PORTS-1];
   noc_pkg::port_vec_t rdy_by_in  [0:`NOC_PORTS-1];
   noc_pkg::port_vec_t gnt_by_in  [0:`NOC_PORTS-1];
   noc_pkg::flit_t     head_flit  [0:`NOC_PORTS-1];

   // Indexed by output port
   noc_pkg::port_vec_t req_by_out [0:`NOC_PORTS-1];
   noc_pkg::port_vec_t rdy_by_out [0:`NOC_PORTS-1];
   noc_pkg::port_vec_t gnt_by_out [0:`NOC_PORTS-1];

   router_cfg u_router_cfg
   (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .my_x      (my_x),
      .my_y      (my_y),
      .out_en    (out_en)
   );

   //////////////////////////////////////////////////////////////////////
   // Input units and output arbiters
   //////////////////////////////////////////////////////////////////////

   for (genvar p = 0; p < `NOC_PORTS; p++)
   begin : g_port
      input_unit u_input_unit
      (
         .clk       (clk),
         .rst       (rst),
         .in_valid  (in_valid[p]),
         .in_flit   (in_flit[p]),
         .in_full   (in_full[p]),
         .my_x      (my_x),
         .my_y      (my_y),
         .gnt       (gnt_by_in[p]),
         .req       (req_by_in[p]),
         .pop_req   (rdy_by_in[p]),
         .head_flit (head_flit[p])
      );

      port_arbiter u_port_arbiter
      (
         .clk (clk),
         .rst (rst),
         .req (req_by_out[p]),
         .en  (out_en[p]),
         .gnt (gnt_by_out[p])
      );
   end

   // Input-major to output-major transposition
   always_comb
   begin
      for (int i = 0; i < `NOC_PORTS; i++)
      begin
         for (int j = 0; j < `NOC_PORTS; j++)
         begin
            req_by_out[j][i] = req_by_in[i][j];
            rdy_by_out[j][i] = rdy_by_in[i][j];
            gnt_by_in[i][j]  = gnt_by_out[j][i];
         end
      end
   end

   crossbar u_crossbar
   (
      .clk        (clk),
      .rst        (rst),
      .gnt_by_out (gnt_by_out),
      .head_flit  (head_flit),
      .req_by_out (rdy_by_out),
      .out_valid  (out_valid),
      .out_flit   (out_flit)
   );

endmodule

// ==== dv/mesh_router_chk.sv ====
`timescale 1ns/10ps
`include "noc_defs.svh"

module mesh_router_chk
(
   input logic               clk,
   input logic               rst,
   input noc_pkg::port_vec_t out_valid,
   input noc_pkg::port_vec_t in_full,
   input noc_pkg::port_vec_t out_en,
   input noc_pkg::port_vec_t gnt_by_out [0:`NOC_PORTS-1],
   input noc_pkg::port_vec_t gnt_by_in  [0:`NOC_PORTS-1],
   input noc_pkg::port_vec_t req_by_out [0:`NOC_PORTS-1]
);

   // Reset clears strobes and full flags
   assert property (@(posedge clk) rst |=> (out_valid == '0 && in_full == '0))
      else $error("out_valid or in_full still high after a reset cycle");

   for (genvar j = 0; j < `NOC_PORTS; j++)
   begin : g_out
      // Requests and grants start low as well
      assert property (@(posedge clk) rst |=> (gnt_by_out[j] == '0 && req_by_out[j] == '0))
         else $error("Output %0d has a request or grant after a reset cycle", j);

      // One input is served by at most one output
      assert property (@(posedge clk) disable iff (rst) $onehot0(gnt_by_in[j]))
         else $error("Input %0d is granted by more than one output", j);

      // Held grant keeps a packet contiguous
      assert property (@(posedge clk) disable iff (rst)
         |(gnt_by_out[j] & req_by_out[j]) |=> gnt_by_out[j] == $past(gnt_by_out[j]))
         else $error("Output %0d dropped a grant its owner still requests", j);

      assert property (@(posedge clk) disable iff (rst)
         (gnt_by_out[j] == '0 && !out_en[j]) |=> gnt_by_out[j] == '0)
         else $error("Disabled output %0d issued a new grant", j);
   end

endmodule

bind mesh_router mesh_router_chk u_mesh_router_chk
(
   .clk        (clk),
   .rst        (rst),
   .out_valid  (out_valid),
   .in_full    (in_full),
   .out_en     (out_en),
   .gnt_by_out (gnt_by_out),
   .gnt_by_in  (gnt_by_in),
   .req_by_out (req_by_out)
);

// ==== dv/mesh_router_tb.sv ====
`timescale 1ns/10ps
`include "noc_defs.svh"

module mesh_router_tb;

   localparam int n_ports    = `NOC_PORTS;
   localparam int max_cycles = 4000;

   // Coordinates (0,0), every output enabled
   localparam noc_pkg::cfg_word_t cfg_reset = {3'd0, 3'd0, 5'b11111};

   logic               clk = 1'b0;
   logic               rst;
   noc_pkg::port_vec_t in_valid;
   noc_pkg::flit_t     in_flit  [0:`NOC_PORTS-1];
   noc_pkg::port_vec_t in_full;
   noc_pkg::port_vec_t out_valid;
   noc_pkg::flit_t     out_flit [0:`NOC_PORTS-1];
   logic               cfg_we;
   noc_pkg::cfg_word_t cfg_wdata;
   noc_pkg::cfg_word_t cfg_rdata;

   // Reference model, one expected queue per output and source
   noc_pkg::coord_t cur_x;
   noc_pkg::coord_t cur_y;
   noc_pkg::flit_t  exp_q [0:`NOC_PORTS*`NOC_PORTS-1][$];
   int              open_src [0:`NOC_PORTS-1];
   int              order_log [$];
   int              log_port = -1;
   int              mismatch_cnt = 0;
   int              fail_cnt = 0;
   int              cycle_cnt = 0;
   integer          seed;

   mesh_router u_mesh_router
   (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .in_full   (in_full),
      .out_valid (out_valid),
      .out_flit  (out_flit),
      .cfg_we    (cfg_we),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= max_cycles)
      begin
         $display("Timeout: run did not finish within %0d cycles", max_cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Reference routing and output monitor
   //////////////////////////////////////////////////////////////////////

   function automatic int xy_port(input noc_pkg::coord_t dx, input noc_pkg::coord_t dy);
      if (dx > cur_x)
         return 2;
      else if (dx < cur_x)
         return 4;
      else if (dy > cur_y)
         return 1;
      else if (dy < cur_y)
         return 3;
      return 0;
   endfunction

   function automatic int pending();
      int total;
      total = 0;
      for (int k = 0; k < n_ports * n_ports; k++)
         total += exp_q[k].size();
      return total;
   endfunction

   // Source id rides in the top payload bits
   always @(negedge clk)
   begin : monitor
      noc_pkg::flit_t got;
      noc_pkg::flit_t want;
      int             src;
      int             idx;
      for (int j = 0; j < n_ports; j++)
      begin
         if (!rst && out_valid[j])
         begin
            got = out_flit[j];
            src = int'(got.payload[`NOC_PAYLOAD_W-1 -: 3]);
            idx = j * n_ports + src;
            assert (src < n_ports && exp_q[idx].size() > 0)
            else
            begin
               mismatch_cnt++;
               $display("Mismatch at %0t: output %0d got unexpected flit %h", $time, j, got);
            end
            if (src < n_ports && exp_q[idx].size() > 0)
            begin
               want = exp_q[idx].pop_front();
               assert (got == want)
               else
               begin
                  mismatch_cnt++;
                  $display("Mismatch at %0t: output %0d got %h, expected %h",
                           $time, j, got, want);
               end
            end
            assert (open_src[j] < 0 || open_src[j] == src)
            else
            begin
               mismatch_cnt++;
               $display("Mismatch at %0t: output %0d mixed input %0d into packet of input %0d",
                        $time, j, src, open_src[j]);
            end
            open_src[j] = got.last ? -1 : src;
            if (j == log_port)
               order_log.push_back(src);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks, all called on a falling edge
   //////////////////////////////////////////////////////////////////////

   task automatic send_flit(input int src, input noc_pkg::flit_t f);
      while (in_full[src])
         @(negedge clk);
      in_flit[src]  = f;
      in_valid[src] = 1'b1;
      exp_q[xy_port(f.dest_x, f.dest_y) * n_ports + src].push_back(f);
      @(negedge clk);
      in_valid[src] = 1'b0;
   endtask

   task automatic send_packet(input int src, input noc_pkg::coord_t dx,
                              input noc_pkg::coord_t dy, input int len);
      noc_pkg::flit_t f;
      for (int k = 0; k < len; k++)
      begin
         f.last    = (k == len - 1);
         f.dest_x  = dx;
         f.dest_y  = dy;
         f.payload = `NOC_PAYLOAD_W'($random(seed));
         f.payload[`NOC_PAYLOAD_W-1 -: 3] = 3'(src);
         send_flit(src, f);
      end
   endtask

   // Two packets of 2 to 4 flits toward east
   task automatic send_burst(input int src);
      int len;
      for (int p = 0; p < 2; p++)
      begin
         len = 2 + int'($unsigned($random(seed)) % 3);
         send_packet(src, 3'd5, 3'd3, len);
      end
   endtask

   task automatic write_cfg(input noc_pkg::coord_t x, input noc_pkg::coord_t y,
                            input noc_pkg::port_vec_t en);
      cfg_wdata = {x, y, en};
      cfg_we    = 1'b1;
      @(negedge clk);
      cfg_we = 1'b0;
      cur_x  = x;
      cur_y  = y;
      assert (cfg_rdata == {x, y, en})
      else
      begin
         mismatch_cnt++;
         $display("Mismatch at %0t: cfg_rdata %h after writing %h", $time, cfg_rdata, {x, y, en});
      end
   endtask

   task automatic wait_drain();
      while (pending() != 0)
         @(posedge clk);
      @(negedge clk);
   endtask

   // Flits still queued or in flight are lost on reset
   task automatic apply_reset();
      rst = 1'b1;
      repeat (5) @(negedge clk);
      rst   = 1'b0;
      cur_x = '0;
      cur_y = '0;
      for (int k = 0; k < n_ports * n_ports; k++)
         exp_q[k].delete();
      for (int j = 0; j < n_ports; j++)
         open_src[j] = -1;
   endtask

   task automatic check_reset_state();
      assert (out_valid == '0 && in_full == '0)
      else
      begin
         fail_cnt++;
         $display("Output strobes or full flags are not low after reset");
      end
      assert (cfg_rdata == cfg_reset)
      else
      begin
         mismatch_cnt++;
         $display("Mismatch at %0t: cfg_rdata %h after reset", $time, cfg_rdata);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      int n1;
      int n4;
      bit in_order;
      int src;
      seed      = 32'h5873;
      rst       = 1'b1;
      in_valid  = '0;
      cfg_we    = 1'b0;
      cfg_wdata = '0;
      for (int j = 0; j < n_ports; j++)
         in_flit[j] = '0;
      apply_reset();
      check_reset_state();

      // Single flits to random destinations, local first
      write_cfg(3'd3, 3'd3, 5'b11111);
      send_packet(2, 3'd3, 3'd3, 1);
      for (int n = 0; n < 24; n++)
      begin
         src = int'($unsigned($random(seed)) % n_ports);
         send_packet(src, noc_pkg::coord_t'($random(seed)), noc_pkg::coord_t'($random(seed)), 1);
      end
      wait_drain();

      // Inputs 1 and 4 race for the local output
      log_port = 0;
      order_log.delete();
      fork
         send_packet(1, 3'd3, 3'd3, 3);
         send_packet(4, 3'd3, 3'd3, 3);
      join
      wait_drain();
      log_port = -1;
      n1       = 0;
      n4       = 0;
      in_order = 1'b1;
      foreach (order_log[k])
      begin
         if (order_log[k] == 1)
         begin
            n1++;
            if (n4 > 0)
               in_order = 1'b0;
         end
         else if (order_log[k] == 4)
            n4++;
      end
      assert (in_order && n1 == 3 && n4 == 3)
      else
      begin
         mismatch_cnt++;
         $display("Mismatch at %0t: input 1 did not win the local output cleanly", $time);
      end

      // Every input sends multi-flit packets to east
      fork
         send_burst(0);
         send_burst(1);
         send_burst(2);
         send_burst(3);
         send_burst(4);
      join
      wait_drain();

      // East disabled, its packets wait and input 0 fills up
      write_cfg(3'd3, 3'd3, 5'b11011);
      for (int n = 0; n < 4; n++)
         send_packet(0, 3'd5, 3'd3, 1);
      send_packet(3, 3'd6, 3'd2, 1);
      repeat (20)
      begin
         @(negedge clk);
         assert (!out_valid[2])
         else
         begin
            fail_cnt++;
            $display("Disabled east output sent a flit at %0t", $time);
         end
      end
      assert (in_full[0])
      else
      begin
         fail_cnt++;
         $display("Input 0 holds four flits but in_full is low");
      end
      write_cfg(3'd3, 3'd3, 5'b11111);
      wait_drain();

      // Readback of another word, then reset hits a full queue and live traffic
      write_cfg(3'd6, 3'd1, 5'b10101);
      for (int n = 0; n < 4; n++)
         send_packet(0, 3'd6, 3'd4, 1);
      send_packet(2, 3'd6, 3'd1, 4);
      apply_reset();
      check_reset_state();

      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt + fail_cnt == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+logic
logic/noc_pkg.sv
logic/router_cfg.sv
logic/input_unit.sv
logic/port_arbiter.sv
logic/crossbar.sv
logic/mesh_router.sv
dv/mesh_router_chk.sv
dv/mesh_router_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mesh router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module mesh_router_tb -Mdir obj_dir -o mesh_router_sim \
   -f src.f > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/mesh_router_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
